// ==== project.f ====
+incdir+hw
hw/dcache_pkg.sv
hw/dcache_lookup_if.sv
hw/dcache_tag_array.sv
hw/dcache_data_array.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
bench/dcache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/dcache_stimulus.txt ====
# op addr wdata wstrb expect hit wb wb_addr, all hex
# op 0 load, 1 store; hit 1 marks a resident line; wb 1 expects one writeback of wb_addr
0 00000014 00000000 0 dead0014 0 0 00000000
0 00000018 00000000 0 dead0018 1 0 00000000
1 00000018 11223344 3 00000000 1 0 00000000
0 00000018 00000000 0 dead3344 1 0 00000000
1 0000001c aabbccdd c 00000000 1 0 00000000
0 0000001c 00000000 0 aabb001c 1 0 00000000
0 00000110 00000000 0 dead0110 0 0 00000000
0 00000210 00000000 0 dead0210 0 1 00000010
0 00000018 00000000 0 dead3344 0 0 00000000
1 00000124 55667788 1 00000000 0 0 00000000
0 00000124 00000000 0 dead0188 1 0 00000000
1 00000020 cafef00d f 00000000 0 0 00000000
0 00000020 00000000 0 cafef00d 1 0 00000000
0 00000224 00000000 0 dead0224 0 1 00000120
0 0000002c 00000000 0 dead002c 1 0 00000000
0 00000324 00000000 0 dead0324 0 0 00000000
0 00000020 00000000 0 cafef00d 1 0 00000000
0 00000120 00000000 0 dead0120 0 0 00000000
0 00000124 00000000 0 dead0188 1 0 00000000
1 00000028 12345678 6 00000000 1 0 00000000
0 00000028 00000000 0 de345628 1 0 00000000
0 00000128 00000000 0 dead0128 1 0 00000000
0 00000420 00000000 0 dead0420 0 1 00000020
0 00000028 00000000 0 de345628 0 0 00000000
1 00000ff4 9a000000 8 00000000 0 0 00000000
0 00000ff4 00000000 0 9aad0ff4 1 0 00000000
0 00000ef0 00000000 0 dead0ef0 0 0 00000000
0 00000df8 00000000 0 dead0df8 0 1 00000ff0
0 00000ff4 00000000 0 9aad0ff4 0 0 00000000

// ==== bench/dcache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

    localparam int LINE_BITS = 128;
    localparam int TIMEOUT   = 200;

    logic                 clk, reset;
    logic                 req_valid, req_write, busy, resp_valid;
    logic [31:0]          req_addr, req_wdata, rdata;
    logic [3:0]           req_wstrb;
    logic                 mem_rd_req, mem_rd_rdy, mem_ret_valid;
    logic                 mem_wr_req, mem_wr_rdy, mem_wr_done;
    logic [31:0]          mem_rd_addr, mem_wr_addr;
    logic [LINE_BITS-1:0] mem_ret_data, mem_wr_data;

    logic [31:0] mem_words [1024];   // 4 KB behind the cache
    logic [31:0] ref_words [1024];

    int          errors, accesses, n_rd, n_wr;
    int          rd_dly, ret_dly, wr_dly, done_dly;
    bit          ret_pend, done_pend, req_seen, hung;
    logic        s_busy, s_resp;
    logic [31:0] s_rdata, last_rd_addr, last_wr_addr;

    dcache_top u_dcache_top (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] fill_pattern(input logic [31:0] addr);
        return 32'hdead_0000 ^ addr;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("[ERROR] %s: got %h expected %h", name, got, exp);
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic check_idle(input string when);
        if ({busy, resp_valid, mem_rd_req, mem_wr_req} !== 4'h0)
            report_mismatch({"busy,resp_valid,mem_rd_req,mem_wr_req ", when},
                            {28'h0, busy, resp_valid, mem_rd_req, mem_wr_req}, 32'h0);
    endtask

    // one clock of the memory model; samples mid-cycle, drives after the edge
    task automatic run_cycle;
        logic                 rd_rdy_n, ret_n, wr_rdy_n, done_n;
        logic [LINE_BITS-1:0] line_n;
        int                   base;
        @(negedge clk);
        s_busy   = busy;
        s_resp   = resp_valid;
        s_rdata  = rdata;
        rd_rdy_n = mem_rd_rdy;
        wr_rdy_n = mem_wr_rdy;
        ret_n    = 1'b0;
        done_n   = 1'b0;
        line_n   = mem_ret_data;
        if (mem_rd_req || mem_wr_req)
            req_seen = 1;
        if (ret_pend) begin
            if (ret_dly == 0) begin
                ret_n    = 1'b1;
                ret_pend = 0;
                base     = int'({last_rd_addr[11:4], 2'b00});
                for (int k = 0; k < 4; k++)
                    line_n[32*k +: 32] = mem_words[base + k];
            end else
                ret_dly--;
        end
        if (mem_rd_req) begin
            if (mem_rd_rdy) begin   // handshake on the coming edge
                n_rd++;
                last_rd_addr = mem_rd_addr;
                ret_pend     = 1;
                ret_dly      = $urandom % 4;
                rd_dly       = $urandom % 4;
                rd_rdy_n     = 1'b0;
            end else if (rd_dly == 0)
                rd_rdy_n = 1'b1;
            else
                rd_dly--;
        end
        if (done_pend) begin
            if (done_dly == 0) begin
                done_n    = 1'b1;
                done_pend = 0;
            end else
                done_dly--;
        end
        if (mem_wr_req) begin
            if (mem_wr_rdy) begin
                n_wr++;
                last_wr_addr = mem_wr_addr;
                base         = int'({mem_wr_addr[11:4], 2'b00});
                for (int k = 0; k < 4; k++) begin
                    if (mem_wr_data[32*k +: 32] !== ref_words[base + k])
                        report_mismatch($sformatf("mem_wr_data word %0d", k),
                                        mem_wr_data[32*k +: 32], ref_words[base + k]);
                    mem_words[base + k] = mem_wr_data[32*k +: 32];
                end
                done_pend = 1;
                done_dly  = $urandom % 4;
                wr_dly    = $urandom % 4;
                wr_rdy_n  = 1'b0;
            end else if (wr_dly == 0)
                wr_rdy_n = 1'b1;
            else
                wr_dly--;
        end
        @(posedge clk);
        #1;
        mem_rd_rdy    = rd_rdy_n;
        mem_ret_valid = ret_n;
        mem_ret_data  = line_n;
        mem_wr_rdy    = wr_rdy_n;
        mem_wr_done   = done_n;
    endtask

    task automatic run_access(input logic [31:0] op, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic [31:0] wstrb,
                              input logic [31:0] expect_data, input logic [31:0] expect_hit,
                              input logic [31:0] expect_wb, input logic [31:0] wb_addr);
        int lat;
        int wait_cnt;
        int rd_before;
        int wr_before;
        bit done;
        rd_before = n_rd;
        wr_before = n_wr;
        req_seen  = 0;
        req_valid = 1'b1;
        req_write = op[0];
        req_addr  = addr;
        req_wdata = wdata;
        req_wstrb = wstrb[3:0];
        done      = 0;
        wait_cnt  = 0;
        while (!done && wait_cnt < TIMEOUT) begin
            run_cycle();
            done = (s_busy === 1'b0);
            wait_cnt++;
        end
        req_valid = 1'b0;
        if (!done) begin
            hung = 1;
            report_failure($sformatf("timeout: request to %h was never accepted", addr));
            return;
        end
        done = 0;
        lat  = 0;
        while (!done && lat < TIMEOUT) begin
            run_cycle();
            lat++;
            done = (s_resp === 1'b1);
        end
        if (!done) begin
            hung = 1;
            report_failure($sformatf("timeout: no response for access to %h", addr));
            return;
        end
        if (op[0] == 1'b0) begin
            if (s_rdata !== ref_words[addr[11:2]])
                report_mismatch($sformatf("rdata @%h", addr), s_rdata, ref_words[addr[11:2]]);
            if (s_rdata !== expect_data)
                report_mismatch($sformatf("rdata @%h (file)", addr), s_rdata, expect_data);
        end
        if (expect_hit[0]) begin
            if (lat != 1)
                report_mismatch("resp_valid latency", lat, 1);
            if (req_seen)
                report_failure($sformatf("memory request during a hit to %h", addr));
        end else if (n_rd - rd_before != 1)
            report_mismatch("refill count", n_rd - rd_before, 1);
        else if (last_rd_addr !== {addr[31:4], 4'h0})
            report_mismatch("mem_rd_addr", last_rd_addr, {addr[31:4], 4'h0});
        if (n_wr - wr_before != expect_wb)
            report_mismatch("writeback count", n_wr - wr_before, expect_wb);
        else if (expect_wb[0] && last_wr_addr !== wb_addr)
            report_mismatch("mem_wr_addr", last_wr_addr, wb_addr);
        if (op[0]) begin   // byte merge into the reference
            for (int b = 0; b < 4; b++)
                if (wstrb[b])
                    ref_words[addr[11:2]][8*b +: 8] = wdata[8*b +: 8];
        end
    endtask

    initial begin
        int               fd;
        logic [8*160-1:0] text;
        logic [31:0]      op, addr, wdata, wstrb, expect_data, expect_hit, expect_wb, wb_addr;

        clk           = 1'b0;
        reset         = 1'b1;
        req_valid     = 1'b0;
        req_write     = 1'b0;
        req_addr      = '0;
        req_wdata     = '0;
        req_wstrb     = '0;
        mem_rd_rdy    = 1'b0;
        mem_ret_valid = 1'b0;
        mem_ret_data  = '0;
        mem_wr_rdy    = 1'b0;
        mem_wr_done   = 1'b0;
        errors        = 0;
        accesses      = 0;
        n_rd          = 0;
        n_wr          = 0;
        hung          = 0;
        ret_pend      = 0;
        done_pend     = 0;
        req_seen      = 0;
        ret_dly       = 0;
        done_dly      = 0;
        void'($urandom(35720));
        rd_dly = $urandom % 4;
        wr_dly = $urandom % 4;
        for (int i = 0; i < 1024; i++) begin
            mem_words[i] = fill_pattern(32'(i * 4));
            ref_words[i] = mem_words[i];
        end

        @(posedge clk);
        @(negedge clk);
        check_idle("in reset");
        @(posedge clk);
        @(negedge clk);
        check_idle("in reset");
        @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        check_idle("after reset");
        @(posedge clk);
        #1;

        fd = $fopen("bench/dcache_stimulus.txt", "r");
        if (fd == 0)
            report_failure("cannot open bench/dcache_stimulus.txt");
        else begin
            while (!$feof(fd) && !hung) begin
                text = '0;
                void'($fgets(text, fd));
                // comment and blank lines do not scan
                if ($sscanf(text, "%h %h %h %h %h %h %h %h", op, addr, wdata, wstrb,
                            expect_data, expect_hit, expect_wb, wb_addr) == 8) begin
                    run_access(op, addr, wdata, wstrb, expect_data, expect_hit,
                               expect_wb, wb_addr);
                    accesses++;
                end
            end
            $fclose(fd);
        end
        if (accesses == 0)
            report_failure("no accesses were run");

        $display("accesses %0d, refills %0d, writebacks %0d, errors %0d",
                 accesses, n_rd, n_wr, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/dcache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache_top (
    input  logic                                             clk,
    input  logic                                             reset,

    input  logic                                             req_valid,
    input  logic                                             req_write,
    input  logic [31:0]                                      req_addr,
    input  logic [`DCACHE_DATA_WIDTH-1:0]                    req_wdata,
    input  logic [`DCACHE_DATA_WIDTH/8-1:0]                  req_wstrb,
    output logic                                             busy,
    output logic                                             resp_valid,
    output logic [`DCACHE_DATA_WIDTH-1:0]                    rdata,

    output logic                                             mem_rd_req,
    output logic [31:0]                                      mem_rd_addr,
    input  logic                                             mem_rd_rdy,
    input  logic                                             mem_ret_valid,
    input  logic [`DCACHE_DATA_WIDTH*`DCACHE_WORDS_PER_LINE-1:0] mem_ret_data,

    output logic                                             mem_wr_req,
    output logic [31:0]                                      mem_wr_addr,
    output logic [`DCACHE_DATA_WIDTH*`DCACHE_WORDS_PER_LINE-1:0] mem_wr_data,
    input  logic                                             mem_wr_rdy,
    input  logic                                             mem_wr_done
);
    import dcache_pkg::*;

    cache_line_t hit_line;
    cache_line_t victim_line;
    cache_line_t fill_line;
    word_t       store_word;

    dcache_lookup_if lk ();

    dcache_tag_array u_tag_array (
        .clk   (clk),
        .reset (reset),
        .lk    (lk.tags)
    );

    dcache_data_array u_data_array (
        .clk         (clk),
        .reset       (reset),
        .lk          (lk.data),
        .fill_line   (fill_line),
        .store_word  (store_word),
        .hit_line    (hit_line),
        .victim_line (victim_line)
    );

    dcache_ctrl u_ctrl (
        .clk           (clk),
        .reset         (reset),
        .lk            (lk.ctrl),
        .req_valid     (req_valid),
        .req_write     (req_write),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .req_wstrb     (req_wstrb),
        .busy          (busy),
        .resp_valid    (resp_valid),
        .rdata         (rdata),
        .mem_rd_req    (mem_rd_req),
        .mem_rd_addr   (mem_rd_addr),
        .mem_rd_rdy    (mem_rd_rdy),
        .mem_ret_valid (mem_ret_valid),
        .mem_ret_data  (mem_ret_data),
        .mem_wr_req    (mem_wr_req),
        .mem_wr_addr   (mem_wr_addr),
        .mem_wr_data   (mem_wr_data),
        .mem_wr_rdy    (mem_wr_rdy),
        .mem_wr_done   (mem_wr_done),
        .hit_line      (hit_line),
        .victim_line   (victim_line),
        .fill_line     (fill_line),
        .store_word    (store_word)
    );

endmodule

`default_nettype wire

// ==== hw/dcache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
    input  logic                    clk,
    input  logic                    reset,
    dcache_lookup_if.ctrl           lk,

    input  logic                    req_valid,
    input  logic                    req_write,
    input  logic [31:0]             req_addr,
    input  dcache_pkg::word_t       req_wdata,
    input  dcache_pkg::strb_t       req_wstrb,
    output logic                    busy,
    output logic                    resp_valid,
    output dcache_pkg::word_t       rdata,

    output logic                    mem_rd_req,
    output logic [31:0]             mem_rd_addr,
    input  logic                    mem_rd_rdy,
    input  logic                    mem_ret_valid,
    input  dcache_pkg::cache_line_t mem_ret_data,
    output logic                    mem_wr_req,
    output logic [31:0]             mem_wr_addr,
    output dcache_pkg::cache_line_t mem_wr_data,
    input  logic                    mem_wr_rdy,
    input  logic                    mem_wr_done,

    input  dcache_pkg::cache_line_t hit_line,
    input  dcache_pkg::cache_line_t victim_line,
    output dcache_pkg::cache_line_t fill_line,
    output dcache_pkg::word_t       store_word
);
    import dcache_pkg::*;

    miss_state_t state;
    miss_state_t state_nxt;

    logic        pending;       // request waiting for its response
    logic        buf_write;
    cache_addr_u buf_addr;
    word_t       buf_wdata;
    strb_t       buf_wstrb;

    cache_addr_u in_addr;
    cache_addr_u rd_line_addr;
    cache_addr_u wr_line_addr;
    logic        accept;
    logic        hit_any;
    word_t       hit_word;

    assign in_addr.word = req_addr;
    assign accept       = req_valid & ~busy;
    assign hit_any      = |lk.hit;

    always_ff @(posedge clk) begin
        if (reset)
            pending <= 1'b0;
        else if (accept)
            pending <= 1'b1;
        else if (resp_valid)
            pending <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            buf_write <= req_write;
            buf_addr  <= in_addr;
            buf_wdata <= req_wdata;
            buf_wstrb <= req_wstrb;
        end
    end

    // re-read the buffered set whenever nothing new is accepted
    assign lk.index_rd   = accept ? in_addr.f.index : buf_addr.f.index;
    assign lk.index_wr   = buf_addr.f.index;
    assign lk.lookup_en  = pending & (state == lookup);
    assign lk.lookup_tag = buf_addr.f.tag;

    assign resp_valid = lk.lookup_en & hit_any;
    assign busy       = (state != lookup) | (pending & (buf_write | ~hit_any));

    assign hit_word = hit_line[buf_addr.f.word];
    assign rdata    = hit_word;

    // byte merge of store data into the hit word
    always_comb begin
        for (int b = 0; b < $bits(strb_t); b++) begin
            store_word[8*b +: 8] = buf_wstrb[b] ? buf_wdata[8*b +: 8] : hit_word[8*b +: 8];
        end
    end

    assign lk.store_en   = resp_valid & buf_write;
    assign lk.store_way  = lk.hit[1];
    assign lk.store_off  = buf_addr.f.word;
    assign lk.mark_dirty = lk.store_en;   // fills are clean

    assign lk.fill_en  = (state == refill_wait) & mem_ret_valid;
    assign lk.fill_tag = buf_addr.f.tag;
    assign fill_line   = mem_ret_data;

    always_comb begin
        rd_line_addr            = buf_addr;
        rd_line_addr.f.word     = '0;
        rd_line_addr.f.byte_off = '0;
        wr_line_addr            = rd_line_addr;
        wr_line_addr.f.tag      = lk.victim_tag;
    end

    assign mem_rd_req  = (state == refill_req);
    assign mem_rd_addr = rd_line_addr.word;
    assign mem_wr_req  = (state == writeback_req);
    assign mem_wr_addr = wr_line_addr.word;
    assign mem_wr_data = victim_line;   // held stable by the re-read

    always_ff @(posedge clk) begin
        if (reset)
            state <= lookup;
        else
            state <= state_nxt;
    end

    always_comb begin
        state_nxt = state;
        case (state)
            lookup: begin
                if (lk.lookup_en & ~hit_any)
                    state_nxt = lk.victim_dirty ? writeback_req : refill_req;
            end
            writeback_req: begin
                if (mem_wr_rdy)
                    state_nxt = writeback_wait;
            end
            writeback_wait: begin
                if (mem_wr_done)
                    state_nxt = refill_req;
            end
            refill_req: begin
                if (mem_rd_rdy)
                    state_nxt = refill_wait;
            end
            refill_wait: begin
                if (mem_ret_valid)
                    state_nxt = refill_done;
            end
            refill_done: state_nxt = lookup;   // arrays re-read here
            default:     state_nxt = lookup;
        endcase
    end

    // request, address and line held until the memory is ready
    a_rd_hold: assert property (@(posedge clk) disable iff (reset)
        mem_rd_req && !mem_rd_rdy |=> mem_rd_req && $stable(mem_rd_addr));

    a_wr_hold: assert property (@(posedge clk) disable iff (reset)
        mem_wr_req && !mem_wr_rdy |=> mem_wr_req && $stable(mem_wr_addr)
            && $stable(mem_wr_data));

    // a miss only answers after the re-read in refill_done
    a_resp_after_lookup: assert property (@(posedge clk) disable iff (reset)
        resp_valid |-> ($past(state) == lookup) || ($past(state) == refill_done));

endmodule

`default_nettype wire

// ==== hw/dcache_data_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_data_array (
    input  logic                    clk,
    input  logic                    reset,
    dcache_lookup_if.data           lk,
    input  dcache_pkg::cache_line_t fill_line,
    input  dcache_pkg::word_t       store_word,
    output dcache_pkg::cache_line_t hit_line,
    output dcache_pkg::cache_line_t victim_line
);
    import dcache_pkg::*;

    cache_line_t rd_line [WAYS];
    logic        wr_ok;

    assign wr_ok = ~reset;   // no array writes while in reset

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        for (genvar k = 0; k < WORDS; k++) begin : g_word
            word_t ram [SETS];
            word_t rd_q;
            logic  we_fill;
            logic  we_store;

            // refill writes the whole line of the victim way
            assign we_fill  = wr_ok & lk.fill_en & (lk.victim_way == way_t'(w));
            assign we_store = wr_ok & lk.store_en & (lk.store_way == way_t'(w))
                            & (lk.store_off == word_off_t'(k));

            always_ff @(posedge clk) begin
                if (we_fill)
                    ram[lk.index_wr] <= fill_line[k];
                else if (we_store)
                    ram[lk.index_wr] <= store_word;
                rd_q <= ram[lk.index_rd];
            end

            assign rd_line[w][k] = rd_q;
        end
    end

    // two ways only
    assign hit_line    = lk.hit[1] ? rd_line[1] : rd_line[0];
    assign victim_line = rd_line[lk.victim_way];

endmodule

`default_nettype wire

// ==== hw/dcache_tag_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_array (
    input logic           clk,
    input logic           reset,
    dcache_lookup_if.tags lk
);
    import dcache_pkg::*;

    logic [SETS-1:0] valid_q [WAYS];
    logic [SETS-1:0] dirty_q [WAYS];
    logic [SETS-1:0] lru_q;            // points at the next victim
    tag_t            tag_mem [WAYS][SETS];

    logic [WAYS-1:0] rd_valid;
    logic [WAYS-1:0] rd_dirty;
    tag_t            rd_tag [WAYS];

    // valid, dirty and replacement state
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < WAYS; w++) begin
                valid_q[w] <= '0;
                dirty_q[w] <= '0;
            end
            lru_q <= '0;
        end else begin
            if (lk.fill_en) begin
                valid_q[lk.victim_way][lk.index_wr] <= 1'b1;
                dirty_q[lk.victim_way][lk.index_wr] <= lk.mark_dirty;
            end
            if (lk.store_en)
                dirty_q[lk.store_way][lk.index_wr] <= lk.mark_dirty;
            if (|lk.hit)
                lru_q[lk.index_wr] <= lk.hit[0];   // the way not hit
        end
    end

    always_ff @(posedge clk) begin
        if (lk.fill_en)
            tag_mem[lk.victim_way][lk.index_wr] <= lk.fill_tag;
    end

    // synchronous read, valid the cycle after the index
    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            rd_tag[w] <= tag_mem[w][lk.index_rd];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid <= '0;
            rd_dirty <= '0;
        end else begin
            for (int w = 0; w < WAYS; w++) begin
                rd_valid[w] <= valid_q[w][lk.index_rd];
                rd_dirty[w] <= dirty_q[w][lk.index_rd];
            end
        end
    end

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            lk.hit[w] = lk.lookup_en & rd_valid[w] & (rd_tag[w] == lk.lookup_tag);
        end
    end

    // lru bit read combinationally so a hit just before is seen
    assign lk.victim_way   = lru_q[lk.index_wr];
    assign lk.victim_dirty = rd_valid[lk.victim_way] & rd_dirty[lk.victim_way];
    assign lk.victim_tag   = rd_tag[lk.victim_way];

    // a refill never duplicates a resident tag
    a_hit_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(lk.hit));

endmodule

`default_nettype wire

// ==== hw/dcache_lookup_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface dcache_lookup_if;
    import dcache_pkg::*;

    index_t          index_rd;     // array read address
    index_t          index_wr;     // set being updated
    logic            lookup_en;
    tag_t            lookup_tag;
    logic [WAYS-1:0] hit;
    way_t            victim_way;
    logic            victim_dirty;
    tag_t            victim_tag;
    logic            fill_en;
    tag_t            fill_tag;
    logic            store_en;
    way_t            store_way;
    word_off_t       store_off;
    logic            mark_dirty;   // dirty value written on fill or store

    modport ctrl (
        output index_rd, index_wr, lookup_en, lookup_tag,
        output fill_en, fill_tag, store_en, store_way, store_off, mark_dirty,
        input  hit, victim_dirty, victim_tag
    );

    modport tags (
        input  index_rd, index_wr, lookup_en, lookup_tag,
        input  fill_en, fill_tag, store_en, store_way, mark_dirty,
        output hit, victim_way, victim_dirty, victim_tag
    );

    modport data (
        input index_rd, index_wr, fill_en, store_en, store_way, store_off,
        input hit, victim_way
    );

endinterface

`default_nettype wire

// ==== hw/dcache_pkg.sv ====
`default_nettype none

`include "dcache_config.svh"

package dcache_pkg;

    localparam int WORD_BITS     = `DCACHE_DATA_WIDTH;
    localparam int WORDS         = `DCACHE_WORDS_PER_LINE;
    localparam int WAYS          = `DCACHE_WAYS;
    localparam int SETS          = `DCACHE_SETS;
    localparam int INDEX_BITS    = $clog2(SETS);
    localparam int WORD_OFF_BITS = $clog2(WORDS);
    localparam int BYTE_OFF_BITS = $clog2(WORD_BITS / 8);
    localparam int OFFSET_BITS   = WORD_OFF_BITS + BYTE_OFF_BITS;
    localparam int TAG_BITS      = 32 - INDEX_BITS - OFFSET_BITS;

    typedef logic [TAG_BITS-1:0]        tag_t;
    typedef logic [INDEX_BITS-1:0]      index_t;
    typedef logic [WORD_OFF_BITS-1:0]   word_off_t;
    typedef logic [$clog2(WAYS)-1:0]    way_t;
    typedef logic [WORD_BITS-1:0]       word_t;
    typedef logic [WORD_BITS/8-1:0]     strb_t;

    typedef logic [WORDS-1:0][WORD_BITS-1:0] cache_line_t;

    typedef struct packed {
        tag_t                     tag;
        index_t                   index;
        word_off_t                word;
        logic [BYTE_OFF_BITS-1:0] byte_off;
    } addr_fields_t;

    // raw address or its cache fields
    typedef union packed {
        logic [31:0]  word;
        addr_fields_t f;
    } cache_addr_u;

    typedef enum logic [2:0] {
        lookup,
        writeback_req,
        writeback_wait,
        refill_req,
        refill_wait,
        refill_done
    } miss_state_t;

endpackage

`default_nettype wire

// ==== hw/dcache_config.svh ====
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// word width in bits
`define DCACHE_DATA_WIDTH 32

// one replacement bit per set, so only 2 ways work
`define DCACHE_WAYS 2

`define DCACHE_WORDS_PER_LINE 4

// any power of two
`define DCACHE_SETS 16

`endif
